//--- files.f
hdl/nes_pkg.sv
hdl/loader_status_if.sv
hdl/nes_config.sv
hdl/ines_loader.sv
hdl/joypad_port.sv
hdl/cheat_collector.sv
hdl/nes_cart_io.sv
verif/tb_nes_cart_io.sv

//--- Bender.yml
package:
  name: nes_cart_io

sources:
  - hdl/nes_pkg.sv
  - hdl/loader_status_if.sv
  - hdl/nes_config.sv
  - hdl/ines_loader.sv
  - hdl/joypad_port.sv
  - hdl/cheat_collector.sv
  - hdl/nes_cart_io.sv
  - target: simulation
    files:
      - verif/tb_nes_cart_io.sv

//--- verif/tb_nes_cart_io.sv
////////////////////////////////////////////////////////////
// Random self-checking testbench of the cartridge input side
// Images stay small (PRG up to 2 pages, CHR up to 1 page)
// Stops at the first wrong value or missing event
////////////////////////////////////////////////////////////

module tb_nes_cart_io;
	import nes_pkg::*;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_PRG    = 128;
	localparam int WAIT_LIMIT = 2000; // Cycles per wait loop

	logic          clk;
	logic          reset_nes;
	logic          cfg_wr;
	logic [2:0]    cfg_data;
	logic          download;
	file_type_t    file_type;
	logic          byte_valid;
	stream_addr_t  byte_addr;
	byte_t         byte_data;
	pad_t          joy_a;
	pad_t          joy_b;
	pad_t          joy_c;
	pad_t          joy_d;
	logic          joypad_strobe;
	logic [1:0]    joypad_clock;
	mem_addr_t     mem_addr;
	byte_t         mem_data;
	logic          mem_write;
	logic          loader_busy;
	mapper_flags_t mapper_flags;
	logic          load_error;
	logic [1:0]    joypad_data;
	cheat_word_t   cheat_flags;
	cheat_word_t   cheat_address;
	cheat_word_t   cheat_compare;
	cheat_word_t   cheat_replace;
	logic          cheat_valid;

	integer        seed = 32'h92bd115b;
	int            write_count = 0;
	int            cheat_pulses = 0;
	mem_addr_t     exp_addr_q [$]; // Writes the model expects, in order
	byte_t         exp_data_q [$];
	mem_addr_t     next_addr;
	byte_t         next_data;
	byte_t         hdr [16];       // Header of the current load

	nes_cart_io #(
		.MAX_PRG_PAGES (MAX_PRG)
	) u_nes_cart_io (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.cfg_wr        (cfg_wr),
		.cfg_data      (cfg_data),
		.download      (download),
		.file_type     (file_type),
		.byte_valid    (byte_valid),
		.byte_addr     (byte_addr),
		.byte_data     (byte_data),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_c         (joy_c),
		.joy_d         (joy_d),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.mem_write     (mem_write),
		.loader_busy   (loader_busy),
		.mapper_flags  (mapper_flags),
		.load_error    (load_error),
		.joypad_data   (joypad_data),
		.cheat_flags   (cheat_flags),
		.cheat_address (cheat_address),
		.cheat_compare (cheat_compare),
		.cheat_replace (cheat_replace),
		.cheat_valid   (cheat_valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks

	task automatic stop_with_failure();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic timeout_failure(input string what);
		$display("timeout while waiting for %s", what);
		stop_with_failure();
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_flags(input string name, input mapper_flags_t exp,
		input mapper_flags_t act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_word(input string name, input cheat_word_t exp, input cheat_word_t act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("mismatch %s expected %0d actual %0d", name, exp, act);
			stop_with_failure();
		end
	endtask

	// Every memory write must match the next modeled one
	always @(negedge clk) begin
		if (mem_write === 1'b1) begin
			if (exp_addr_q.size() == 0) begin
				$display("mem_write at address %h while no write was expected", mem_addr);
				stop_with_failure();
			end else begin
				next_addr = exp_addr_q.pop_front();
				next_data = exp_data_q.pop_front();
				check_addr("memory write address", next_addr, mem_addr);
				check_byte("memory write data", next_data, mem_data);
				write_count++;
			end
		end
		if (cheat_valid === 1'b1)
			cheat_pulses++;
	end

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [2:0] page_code(input byte_t pages);
		logic [2:0] code;
		logic       found;
		code  = 3'd7;
		found = 1'b0;
		for (int n = 0; n < 7; n++) begin
			if (!found && pages <= (9'd1 << n)) begin
				code  = 3'(n);
				found = 1'b1;
			end
		end
		return code;
	endfunction

	function automatic mapper_flags_t model_flags(input logic inv);
		logic  nes20;
		logic  dirty;
		byte_t sub;
		nes20 = (hdr[7][3:2] == 2'b10);
		dirty = !nes20 && ((hdr[9][7:1] != 0) || (hdr[10] != 0) || (hdr[11] != 0)
			|| (hdr[12] != 0) || (hdr[13] != 0) || (hdr[14] != 0) || (hdr[15] != 0));
		sub   = nes20 ? hdr[8] : 8'h00;
		return {6'b0, hdr[6][1], sub, hdr[6][3], hdr[5] == 0, hdr[6][0] ^ inv,
			page_code(hdr[5]), page_code(hdr[4]), dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	endfunction

	// A, B, select, start, up, down, left, right leave first to last
	function automatic pad_t nes_order(input pad_t host);
		pad_t r;
		r[0] = host[4];
		r[1] = host[5];
		r[2] = host[6];
		r[3] = host[7];
		r[4] = host[3];
		r[5] = host[2];
		r[6] = host[1];
		r[7] = host[0];
		return r;
	endfunction

	function automatic serial_t port_model(input pad_t first, input pad_t tap, input byte_t id,
		input logic mtap);
		if (mtap)
			return {id, nes_order(tap), nes_order(first)};
		return {16'hFFFF, nes_order(first)};
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus tasks

	task automatic write_cfg(input logic inv, input logic swap, input logic mtap);
		@(posedge clk);
		cfg_wr   <= 1'b1;
		cfg_data <= {mtap, swap, inv};
		@(posedge clk);
		cfg_wr   <= 1'b0;
	endtask

	// Random idle gap, then a one-cycle strobe
	task automatic send_byte(input stream_addr_t a, input byte_t d);
		int gap;
		gap = $unsigned($random(seed)) % 3;
		repeat (gap) begin
			@(posedge clk);
			byte_valid <= 1'b0;
		end
		@(posedge clk);
		byte_valid <= 1'b1;
		byte_addr  <= a;
		byte_data  <= d;
	endtask

	task automatic stream_idle();
		@(posedge clk);
		byte_valid <= 1'b0;
	endtask

	task automatic wait_busy(input logic level, input string what);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (loader_busy !== level) begin
			if (cycles == WAIT_LIMIT)
				timeout_failure(what);
			@(negedge clk);
			cycles++;
		end
	endtask

	// Kind 0 NES 2.0, 1 dirty, 2 clean iNES 1.0
	task automatic build_header(input byte_t prg, input byte_t chr, input int kind);
		hdr[0] = 8'h4E;
		hdr[1] = 8'h45;
		hdr[2] = 8'h53;
		hdr[3] = 8'h1A;
		hdr[4] = prg;
		hdr[5] = chr;
		for (int i = 6; i < 16; i++)
			hdr[i] = $random(seed);
		hdr[6][2] = 1'b0;
		if (kind == 0) begin
			hdr[7][3:2] = 2'b10;
		end else begin
			hdr[7][3] = 1'b0;
			if (kind == 1) begin
				hdr[10] = hdr[10] | 8'h01;
			end else begin
				hdr[9][7:1] = '0;
				for (int i = 10; i < 16; i++)
					hdr[i] = 8'h00;
			end
		end
	endtask

	task automatic run_load(input logic inv, input logic expect_ok, input string name);
		int    total;
		byte_t d;
		total = expect_ok ? hdr[4] * PRG_PAGE_BYTES + hdr[5] * CHR_PAGE_BYTES : 0;
		write_count = 0;
		@(posedge clk);
		download  <= 1'b1;
		file_type <= 8'h01;
		for (int i = 0; i < HEADER_BYTES; i++)
			send_byte(stream_addr_t'(i), hdr[i]);
		stream_idle();
		wait_busy(1'b1, {name, " busy rise"});
		if (expect_ok) begin
			for (int i = 0; i < hdr[4] * PRG_PAGE_BYTES; i++) begin
				d = $random(seed);
				exp_addr_q.push_back(mem_addr_t'(i));
				exp_data_q.push_back(d);
				send_byte(stream_addr_t'(HEADER_BYTES + i), d);
			end
			for (int i = 0; i < hdr[5] * CHR_PAGE_BYTES; i++) begin
				d = $random(seed);
				exp_addr_q.push_back(22'h200000 + mem_addr_t'(i));
				exp_data_q.push_back(d);
				send_byte(stream_addr_t'(HEADER_BYTES + hdr[4] * PRG_PAGE_BYTES + i), d);
			end
			stream_idle();
		end
		wait_busy(1'b0, {name, " busy fall"});
		@(posedge clk);
		download <= 1'b0;
		@(negedge clk); // Result registered one cycle after done
		if (expect_ok)
			check_flags({name, " mapper_flags"}, model_flags(inv), mapper_flags);
		check_bit({name, " load_error"}, !expect_ok, load_error);
		check_count({name, " write count"}, total, write_count);
		check_count({name, " writes left"}, 0, exp_addr_q.size());
	endtask

	task automatic run_joypad(input string name);
		pad_t    pa;
		pad_t    pb;
		pad_t    pc;
		pad_t    pd;
		logic    swap;
		logic    mtap;
		serial_t exp0;
		serial_t exp1;
		pa   = $random(seed);
		pb   = $random(seed);
		pc   = $random(seed);
		pd   = $random(seed);
		swap = $random(seed);
		mtap = $random(seed);
		write_cfg(1'b0, swap, mtap);
		exp0 = port_model(swap ? pb : pa, pc, PORT3_ID, mtap);
		exp1 = port_model(swap ? pa : pb, pd, PORT4_ID, mtap);
		@(posedge clk);
		joy_a         <= pa;
		joy_b         <= pb;
		joy_c         <= pc;
		joy_d         <= pd;
		joypad_strobe <= 1'b1;
		@(posedge clk);
		joypad_strobe <= 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_bit($sformatf("%s port 0 bit 0", name), exp0[0], joypad_data[0]);
		check_bit($sformatf("%s port 1 bit 0", name), exp1[0], joypad_data[1]);
		for (int k = 1; k < 27; k++) begin
			@(posedge clk);
			joypad_clock <= 2'b00;
			repeat (4) @(posedge clk); // Sample, shift, output register
			@(negedge clk);
			check_bit($sformatf("%s port 0 bit %0d", name, k),
				(k < 24) ? exp0[k] : 1'b0, joypad_data[0]);
			check_bit($sformatf("%s port 1 bit %0d", name, k),
				(k < 24) ? exp1[k] : 1'b0, joypad_data[1]);
			@(posedge clk);
			joypad_clock <= 2'b11;
			repeat (3) @(posedge clk);
		end
	endtask

	task automatic run_cheat(input string name);
		byte_t rec [16];
		int    cycles;
		for (int i = 0; i < 16; i++)
			rec[i] = $random(seed);
		cheat_pulses = 0;
		write_count  = 0;
		@(posedge clk);
		download  <= 1'b1;
		file_type <= CHEAT_FILE_TYPE;
		for (int i = 0; i < 16; i++)
			send_byte(24'h000340 + stream_addr_t'(i), rec[i]); // Upper address bits ignored
		stream_idle();
		cycles = 0;
		@(negedge clk);
		while (cheat_pulses == 0) begin
			if (cycles == WAIT_LIMIT)
				timeout_failure({name, " cheat_valid"});
			@(negedge clk);
			cycles++;
		end
		check_word({name, " flags"}, {rec[3], rec[2], rec[1], rec[0]}, cheat_flags);
		check_word({name, " address"}, {rec[7], rec[6], rec[5], rec[4]}, cheat_address);
		check_word({name, " compare"}, {rec[11], rec[10], rec[9], rec[8]}, cheat_compare);
		check_word({name, " replace"}, {rec[15], rec[14], rec[13], rec[12]}, cheat_replace);
		repeat (4) @(posedge clk);
		download <= 1'b0;
		@(negedge clk);
		check_count({name, " valid pulses"}, 1, cheat_pulses);
		check_count({name, " write count"}, 0, write_count);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic  inv;
		byte_t prg;
		byte_t chr;
		reset_nes     = 1'b1;
		cfg_wr        = 1'b0;
		cfg_data      = '0;
		download      = 1'b0;
		file_type     = '0;
		byte_valid    = 1'b0;
		byte_addr     = '0;
		byte_data     = '0;
		joy_a         = '0;
		joy_b         = '0;
		joy_c         = '0;
		joy_d         = '0;
		joypad_strobe = 1'b0;
		joypad_clock  = 2'b11; // Idle high, edges are falling
		repeat (10) @(posedge clk);
		reset_nes <= 1'b0;
		@(negedge clk);

		check_bit("reset mem_write", 1'b0, mem_write);
		check_bit("reset loader_busy", 1'b0, loader_busy);
		check_bit("reset cheat_valid", 1'b0, cheat_valid);
		check_bit("reset load_error", 1'b0, load_error);
		check_flags("reset mapper_flags", '0, mapper_flags);
		check_bit("reset joypad_data 0", 1'b0, joypad_data[0]);
		check_bit("reset joypad_data 1", 1'b0, joypad_data[1]);

		// Valid images, writes and flags together
		for (int n = 0; n < 6; n++) begin
			prg = 1 + $unsigned($random(seed)) % 2;
			chr = $unsigned($random(seed)) % 2;
			inv = $random(seed);
			write_cfg(inv, 1'b0, 1'b0);
			build_header(prg, chr, n % 3);
			run_load(inv, 1'b1, $sformatf("load %0d", n));
		end

		build_header(8'd1, 8'd1, 2);
		hdr[1] = hdr[1] ^ 8'h20;
		run_load(1'b0, 1'b0, "bad signature");
		build_header(8'd1, 8'd1, 0);
		hdr[6][2] = 1'b1;
		run_load(1'b0, 1'b0, "trainer present");
		build_header(byte_t'(MAX_PRG + 1 + $unsigned($random(seed)) % (255 - MAX_PRG)), 8'd0, 1);
		run_load(1'b0, 1'b0, "too many PRG pages");

		for (int n = 0; n < 6; n++)
			run_joypad($sformatf("joypad %0d", n));

		run_cheat("cheat record");

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- hdl/nes_cart_io.sv
////////////////////////////////////////////////////////////
// Cartridge download and controller input side of the core
// Byte strobes are single cycle, nothing is ever stalled
////////////////////////////////////////////////////////////

module nes_cart_io #(
	parameter int MAX_PRG_PAGES = 128
) (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   cfg_wr,
	input  logic [2:0]             cfg_data,
	input  logic                   download,
	input  nes_pkg::file_type_t    file_type,
	input  logic                   byte_valid,
	input  nes_pkg::stream_addr_t  byte_addr,
	input  nes_pkg::byte_t         byte_data,
	input  nes_pkg::pad_t          joy_a,
	input  nes_pkg::pad_t          joy_b,
	input  nes_pkg::pad_t          joy_c,
	input  nes_pkg::pad_t          joy_d,
	input  logic                   joypad_strobe,
	input  logic [1:0]             joypad_clock,
	output nes_pkg::mem_addr_t     mem_addr,
	output nes_pkg::byte_t         mem_data,
	output logic                   mem_write,
	output logic                   loader_busy,
	output nes_pkg::mapper_flags_t mapper_flags,
	output logic                   load_error,
	output logic [1:0]             joypad_data,
	output nes_pkg::cheat_word_t   cheat_flags,
	output nes_pkg::cheat_word_t   cheat_address,
	output nes_pkg::cheat_word_t   cheat_compare,
	output nes_pkg::cheat_word_t   cheat_replace,
	output logic                   cheat_valid
);

	logic invert_mirroring;
	logic port_swap;
	logic multitap;
	logic rom_load;
	logic cheat_load;

	loader_status_if u_loader_status ();

	assign mem_data = byte_data; // Payload goes to memory as received

	nes_config u_nes_config (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.cfg_wr           (cfg_wr),
		.cfg_data         (cfg_data),
		.download         (download),
		.file_type        (file_type),
		.status           (u_loader_status),
		.invert_mirroring (invert_mirroring),
		.port_swap        (port_swap),
		.multitap         (multitap),
		.rom_load         (rom_load),
		.cheat_load       (cheat_load),
		.mapper_flags     (mapper_flags),
		.load_error       (load_error),
		.loader_busy      (loader_busy)
	);

	ines_loader #(
		.MAX_PRG_PAGES (MAX_PRG_PAGES)
	) u_ines_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.rom_load         (rom_load),
		.byte_valid       (byte_valid),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.mem_addr         (mem_addr),
		.mem_write        (mem_write),
		.status           (u_loader_status)
	);

	joypad_port u_joypad_port (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_c         (joy_c),
		.joy_d         (joy_d),
		.port_swap     (port_swap),
		.multitap      (multitap),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data)
	);

	cheat_collector u_cheat_collector (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.cheat_load    (cheat_load),
		.byte_valid    (byte_valid),
		.byte_addr     (byte_addr),
		.byte_data     (byte_data),
		.cheat_flags   (cheat_flags),
		.cheat_address (cheat_address),
		.cheat_compare (cheat_compare),
		.cheat_replace (cheat_replace),
		.cheat_valid   (cheat_valid)
	);

endmodule

//--- hdl/cheat_collector.sv
////////////////////////////////////////////////////////////
// Cheat record assembly, 16 bytes, little endian fields
// Only the low four stream address bits select the slot
////////////////////////////////////////////////////////////

module cheat_collector (
	input  logic                  clk,
	input  logic                  reset_nes,
	input  logic                  cheat_load,
	input  logic                  byte_valid,
	input  nes_pkg::stream_addr_t byte_addr,
	input  nes_pkg::byte_t        byte_data,
	output nes_pkg::cheat_word_t  cheat_flags,
	output nes_pkg::cheat_word_t  cheat_address,
	output nes_pkg::cheat_word_t  cheat_compare,
	output nes_pkg::cheat_word_t  cheat_replace,
	output logic                  cheat_valid
);
	import nes_pkg::*;

	cheat_word_t words [4]; // Flags, address, compare, replace
	logic        take;

	assign take = cheat_load && byte_valid;

	// Bits 3:2 pick the word, bits 1:0 the byte lane
	always_ff @(posedge clk) begin
		if (take)
			words[byte_addr[3:2]][{byte_addr[1:0], 3'b000} +: 8] <= byte_data;
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= take && (byte_addr[3:0] == 4'hF);
	end

	assign cheat_flags   = words[0];
	assign cheat_address = words[1];
	assign cheat_compare = words[2];
	assign cheat_replace = words[3];

endmodule

//--- hdl/joypad_port.sv
////////////////////////////////////////////////////////////
// Two NES controller shift ports, 24 bits each
// joypad_clock is sampled twice, no other synchronizer
////////////////////////////////////////////////////////////

module joypad_port (
	input  logic          clk,
	input  logic          reset_nes,
	input  nes_pkg::pad_t joy_a,
	input  nes_pkg::pad_t joy_b,
	input  nes_pkg::pad_t joy_c,
	input  nes_pkg::pad_t joy_d,
	input  logic          port_swap,
	input  logic          multitap,
	input  logic          joypad_strobe,
	input  logic [1:0]    joypad_clock,
	output logic [1:0]    joypad_data
);
	import nes_pkg::*;

	serial_t    shift_q [2];
	serial_t    load_val [2];
	logic [1:0] clock_smp;
	logic [1:0] clock_prev;
	logic [1:0] clock_fall;

	// Host order to NES order, A leaves first
	function automatic pad_t to_nes(input pad_t host);
		return {host[0], host[1], host[2], host[3], host[7], host[6], host[5], host[4]};
	endfunction

	// Without multitap the upper bits read as released buttons
	assign load_val[0] = {multitap ? {PORT3_ID, to_nes(joy_c)} : 16'hFFFF,
		to_nes(port_swap ? joy_b : joy_a)};
	assign load_val[1] = {multitap ? {PORT4_ID, to_nes(joy_d)} : 16'hFFFF,
		to_nes(port_swap ? joy_a : joy_b)};

	assign clock_fall = clock_prev & ~clock_smp;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			clock_smp   <= '0;
			clock_prev  <= '0;
			joypad_data <= '0;
			for (int p = 0; p < 2; p++)
				shift_q[p] <= '0;
		end else begin
			clock_smp  <= joypad_clock;
			clock_prev <= clock_smp;
			for (int p = 0; p < 2; p++) begin
				joypad_data[p] <= shift_q[p][0];
				if (joypad_strobe)
					shift_q[p] <= load_val[p];     // Keeps reloading while strobe is high
				else if (clock_fall[p])
					shift_q[p] <= shift_q[p] >> 1; // Zero fill
			end
		end
	end

endmodule

//--- hdl/ines_loader.sv
////////////////////////////////////////////////////////////
// iNES loader, header bytes are kept here and never written out
// No trainer support, PRG page count limited by MAX_PRG_PAGES
// Every byte strobe is taken, there is no back-pressure
////////////////////////////////////////////////////////////

module ines_loader #(
	parameter int MAX_PRG_PAGES = 128
) (
	input  logic               clk,
	input  logic               reset_nes,
	input  logic               rom_load,
	input  logic               byte_valid,
	input  nes_pkg::byte_t     byte_data,
	input  logic               invert_mirroring,
	output nes_pkg::mem_addr_t mem_addr,
	output logic               mem_write,
	loader_status_if.loader    status
);
	import nes_pkg::*;

	localparam int HDR_IDX_W = $clog2(HEADER_BYTES);

	loader_state_t        state;
	logic [HDR_IDX_W-1:0] hdr_idx;
	logic [HDR_IDX_W-1:0] hdr_slot;
	byte_t                ines [HEADER_BYTES];
	mem_addr_t            bytes_left;
	logic                 rom_load_q;
	logic                 load_start;
	logic                 hdr_take;
	logic                 take;
	logic                 last_byte;
	logic                 header_ok;
	logic                 is_nes20;
	logic                 is_dirty;
	logic                 chr_ram;
	logic                 done;
	logic                 error;
	logic                 busy;
	byte_t                prg_pages;
	byte_t                chr_pages;

	// Smallest n with pages <= 2**n, saturating at 7
	function automatic logic [2:0] size_code(input byte_t pages);
		logic [2:0] code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if (int'(pages) <= (1 << n))
				code = n[2:0];
		end
		return code;
	endfunction

	////////////////////////////////////////////////////////////
	// Header decode

	assign prg_pages = ines[4];
	assign chr_pages = ines[5];
	assign chr_ram   = (chr_pages == '0);
	assign is_nes20  = (ines[7][3:2] == 2'b10);

	// Old dumps often carry junk in the tail bytes
	assign is_dirty = !is_nes20 && |{ines[9][7:1], ines[10], ines[11], ines[12],
		ines[13], ines[14], ines[15]};

	assign header_ok = ({ines[0], ines[1], ines[2], ines[3]} == NES_SIGNATURE)
		&& !ines[6][2]                   // Trainer present
		&& (prg_pages <= MAX_PRG_PAGES);

	assign status.flags = {6'b0, ines[6][1], is_nes20 ? ines[8] : 8'h00, ines[6][3], chr_ram,
		ines[6][0] ^ invert_mirroring, size_code(chr_pages), size_code(prg_pages),
		is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};

	assign status.done  = done;
	assign status.error = error;
	assign status.busy  = busy;

	////////////////////////////////////////////////////////////
	// Byte acceptance

	assign load_start = rom_load && !rom_load_q;
	assign hdr_take   = byte_valid && rom_load && (load_start || state == LOAD_HEADER);
	assign hdr_slot   = load_start ? '0 : hdr_idx; // First byte may arrive with the start
	assign take = byte_valid && rom_load && !load_start && (bytes_left != '0)
		&& (state == LOAD_PRG || state == LOAD_CHR);
	assign last_byte = (bytes_left == '0) || (take && bytes_left == mem_addr_t'(1));

	assign mem_write = take;

	always_ff @(posedge clk) begin
		if (hdr_take)
			ines[hdr_slot] <= byte_data;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= LOAD_HEADER;
			hdr_idx    <= '0;
			bytes_left <= '0;
			mem_addr   <= '0;
			rom_load_q <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
			busy       <= 1'b0;
		end else begin
			rom_load_q <= rom_load;
			done       <= 1'b0;
			if (load_start) begin
				state   <= LOAD_HEADER;
				hdr_idx <= byte_valid ? HDR_IDX_W'(1) : '0;
				error   <= 1'b0;
				busy    <= 1'b0;
			end else begin
				case (state)
				LOAD_HEADER: begin
					if (hdr_take) begin
						hdr_idx <= hdr_idx + 1'b1;
						if (hdr_idx == HDR_IDX_W'(HEADER_BYTES - 1)) begin
							busy <= 1'b1;
							if (header_ok) begin
								state      <= LOAD_PRG;
								mem_addr   <= '0;
								bytes_left <= mem_addr_t'(prg_pages * PRG_PAGE_BYTES);
							end else begin
								state <= LOAD_ERROR;
							end
						end
					end
				end
				LOAD_PRG, LOAD_CHR: begin
					if (take) begin
						bytes_left <= bytes_left - 1'b1;
						mem_addr   <= mem_addr + 1'b1;
					end
					if (last_byte) begin
						if (state == LOAD_PRG && !chr_ram) begin
							state      <= LOAD_CHR;
							mem_addr   <= CHR_BASE;
							bytes_left <= mem_addr_t'(chr_pages * CHR_PAGE_BYTES);
						end else begin
							state <= LOAD_DONE;
							done  <= 1'b1;
							busy  <= 1'b0;
						end
					end
				end
				LOAD_ERROR: begin
					state <= LOAD_DONE;
					done  <= 1'b1;
					error <= 1'b1;
					busy  <= 1'b0;
				end
				default: ; // Idle until the next download
				endcase
			end
		end
	end

endmodule

//--- hdl/nes_config.sv
////////////////////////////////////////////////////////////
// User options, stream steering and last load result
// Options apply one cycle after the cfg_wr strobe
////////////////////////////////////////////////////////////

module nes_config (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   cfg_wr,
	input  logic [2:0]             cfg_data,
	input  logic                   download,
	input  nes_pkg::file_type_t    file_type,
	loader_status_if.cfg           status,
	output logic                   invert_mirroring,
	output logic                   port_swap,
	output logic                   multitap,
	output logic                   rom_load,
	output logic                   cheat_load,
	output nes_pkg::mapper_flags_t mapper_flags,
	output logic                   load_error,
	output logic                   loader_busy
);
	import nes_pkg::*;

	logic is_cheat;

	// Anything that is not a cheat file goes to the ROM loader
	assign is_cheat   = (file_type == CHEAT_FILE_TYPE);
	assign rom_load   = download && !is_cheat;
	assign cheat_load = download && is_cheat;

	assign loader_busy = status.busy;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			invert_mirroring <= 1'b0;
			port_swap        <= 1'b0;
			multitap         <= 1'b0;
		end else if (cfg_wr) begin
			invert_mirroring <= cfg_data[CFG_INVERT_BIT];
			port_swap        <= cfg_data[CFG_SWAP_BIT];
			multitap         <= cfg_data[CFG_MULTITAP_BIT];
		end
	end

	// Keep result of the last finished load
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			mapper_flags <= '0;
			load_error   <= 1'b0;
		end else if (status.done) begin
			mapper_flags <= status.flags;
			load_error   <= status.error;
		end
	end

endmodule

//--- hdl/loader_status_if.sv
////////////////////////////////////////////////////////////
// Loader result towards the configuration block
// done is a one-cycle pulse, error is valid with it
////////////////////////////////////////////////////////////

interface loader_status_if;
	import nes_pkg::*;

	mapper_flags_t flags;
	logic          done;
	logic          error;
	logic          busy;   // Payload transfer in progress

	modport loader (
		output flags,
		output done,
		output error,
		output busy
	);

	modport cfg (
		input flags,
		input done,
		input error,
		input busy
	);

endinterface

//--- hdl/nes_pkg.sv
////////////////////////////////////////////////////////////
// Shared types and constants of the cartridge input side
// Memory is byte addressed, 22 bits, CHR space starts at 2 MB
////////////////////////////////////////////////////////////

package nes_pkg;

	////////////////////////////////////////////////////////////
	// Data widths

	typedef logic [7:0]  byte_t;         // Stream and memory data
	typedef logic [21:0] mem_addr_t;     // Cartridge memory byte address
	typedef logic [23:0] stream_addr_t;  // Offset in the download stream
	typedef logic [7:0]  file_type_t;    // Host file index
	typedef logic [31:0] mapper_flags_t; // Packed load result
	typedef logic [7:0]  pad_t;          // Host button order
	typedef logic [23:0] serial_t;       // One controller port
	typedef logic [31:0] cheat_word_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_DONE,
		LOAD_ERROR
	} loader_state_t;

	////////////////////////////////////////////////////////////
	// iNES layout

	localparam int HEADER_BYTES   = 16;
	localparam int PRG_PAGE_BYTES = 16384;
	localparam int CHR_PAGE_BYTES = 8192;

	localparam mem_addr_t CHR_BASE = 22'h200000;

	// "NES" followed by EOF
	localparam logic [31:0] NES_SIGNATURE = {8'h4E, 8'h45, 8'h53, 8'h1A};

	// Cheat records come in under the last file index
	localparam file_type_t CHEAT_FILE_TYPE = '1;

	////////////////////////////////////////////////////////////
	// Controllers and options

	// Multitap signature bytes, shifted out after pads C and D
	localparam byte_t PORT3_ID = 8'h08;
	localparam byte_t PORT4_ID = 8'h04;

	localparam int CFG_INVERT_BIT   = 0;
	localparam int CFG_SWAP_BIT     = 1;
	localparam int CFG_MULTITAP_BIT = 2;

endpackage
